/* rtl/clic_pkg.sv */
// Shared CLIC types for machine mode only; mintstatus keeps the saved level (mpil) in its low byte
package clic_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // CSR selection and bit positions
  ////////////////////////////////////////////////////////////////////////////

  // Software CSR select codes
  typedef enum logic [2:0] {
    CSR_MTVEC      = 3'd0,
    CSR_MTVT       = 3'd1,
    CSR_MINTTHRESH = 3'd2,
    CSR_MINTSTATUS = 3'd3,
    CSR_MSTATUS    = 3'd4
  } csr_sel_e;

  // Interrupt enable bits inside mstatus
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

  ////////////////////////////////////////////////////////////////////////////
  // Shared structs
  ////////////////////////////////////////////////////////////////////////////

  // Current level on top, saved level in the byte that user mode would use
  typedef struct packed {
    logic [7:0]  mil;
    logic [15:0] rsvd;
    logic [7:0]  mpil;
  } mintstatus_t;

  // One software CSR access, completes in a single cycle
  typedef struct packed {
    csr_sel_e    sel;
    logic        we;
    logic [31:0] wdata;
  } csr_cmd_t;

  // Write of one line's configuration
  typedef struct packed {
    logic [7:0] idx;
    logic       ie;
    logic [7:0] level;
    logic       shv;
  } irq_cfg_t;

  // Winning line from the arbiter; only low ID_WIDTH bits of id are used
  typedef struct packed {
    logic       valid;
    logic [7:0] id;
    logic [7:0] level;
    logic       shv;
  } clic_sel_t;

  // Trap as offered to the core
  typedef struct packed {
    logic [7:0]  id;
    logic [7:0]  level;
    logic        shv;
    logic [31:0] addr;
  } trap_t;

endpackage

/* rtl/clic_arbiter.sv */
// Level-sensitive lines only, sampled once with no synchronizer; NUM_IRQ from 2 to 256
`timescale 1ns/1ns

module clic_arbiter import clic_pkg::*; #(
  parameter int NUM_IRQ  = 16,
  parameter int ID_WIDTH = 4
) (
  input  logic               clk,
  input  logic               rst_n,

  // Raw interrupt lines
  input  logic [NUM_IRQ-1:0] irq_i,

  // Configuration write port
  input  logic               cfg_valid_i,
  input  irq_cfg_t           cfg_i,
  output logic               cfg_ready_o,

  // Selection towards the interrupt gate
  output clic_sel_t          sel_o,
  output clic_sel_t          sel_now_o
);

  // Per-line configuration
  logic               ie_q    [NUM_IRQ];
  logic [7:0]         level_q [NUM_IRQ];
  logic               shv_q   [NUM_IRQ];

  // Sampled lines
  logic [NUM_IRQ-1:0] pend_q;

  logic               cfg_we;
  clic_sel_t          sel_now;
  clic_sel_t          sel_q;

  ////////////////////////////////////////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////////////////////////////////////////

  // Ready only drops during reset
  assign cfg_ready_o = rst_n;

  // Writes to an index beyond the last line are dropped
  assign cfg_we = cfg_valid_i && cfg_ready_o && (int'(cfg_i.idx) < NUM_IRQ);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_IRQ; i++) begin
        ie_q[i]    <= 1'b0;
        level_q[i] <= 8'd0;
        shv_q[i]   <= 1'b0;
      end
    end else if (cfg_we) begin
      ie_q[cfg_i.idx[ID_WIDTH-1:0]]    <= cfg_i.ie;
      level_q[cfg_i.idx[ID_WIDTH-1:0]] <= cfg_i.level;
      shv_q[cfg_i.idx[ID_WIDTH-1:0]]   <= cfg_i.shv;
    end
  end

  // Pending bits follow the lines one cycle late
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= '0;
    end else begin
      pend_q <= irq_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Maximum level search
  ////////////////////////////////////////////////////////////////////////////

  // Strict compare keeps the lowest id on a tie
  // Starting from level 0 means level 0 lines never win
  always_comb begin
    sel_now = '0;
    for (int i = 0; i < NUM_IRQ; i++) begin
      if (ie_q[i] && pend_q[i] && (level_q[i] > sel_now.level)) begin
        sel_now.valid                = 1'b1;
        sel_now.id                   = '0;
        sel_now.id[ID_WIDTH-1:0]     = ID_WIDTH'(i);
        sel_now.level                = level_q[i];
        sel_now.shv                  = shv_q[i];
      end
    end
  end

  // Registered copy for the gate
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      sel_q <= '0;
    end else begin
      sel_q <= sel_now;
    end
  end

  assign sel_now_o = sel_now;
  assign sel_o     = sel_q;

  // A valid winner never carries level 0
  a_sel_level: assert property (@(posedge clk) disable iff (!rst_n)
    sel_o.valid |-> (sel_o.level != 8'd0))
    else $error("arbiter selected a level 0 line");

endmodule

/* rtl/clic_int_gate.sv */
// Machine mode only; wake-up ignores mie and assumes the clock keeps running
`timescale 1ns/1ns

module clic_int_gate import clic_pkg::*; #(
  parameter int ID_WIDTH = 4
) (
  input  logic        clk,
  input  logic        rst_n,

  // From the arbiter
  input  clic_sel_t   sel_i,
  input  clic_sel_t   sel_now_i,

  // From the CSR block
  input  logic        mie_i,
  input  logic [7:0]  mintthresh_i,
  input  mintstatus_t mintstatus_i,

  // To the trap controller
  output logic        irq_req_o,
  output clic_sel_t   irq_sel_o,
  output logic        wakeup_o
);

  logic                valid_q;
  logic [ID_WIDTH-1:0] id_q;
  logic [7:0]          level_q;
  logic                shv_q;

  logic [7:0]          eff_level;

  ////////////////////////////////////////////////////////////////////////////
  // Selection register
  ////////////////////////////////////////////////////////////////////////////

  // Valid tracks the arbiter every cycle
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= sel_i.valid;
    end
  end

  // Payload holds the last valid selection
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      id_q    <= '0;
      level_q <= 8'd0;
      shv_q   <= 1'b0;
    end else if (sel_i.valid) begin
      id_q    <= sel_i.id[ID_WIDTH-1:0];
      level_q <= sel_i.level;
      shv_q   <= sel_i.shv;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Threshold and enable
  ////////////////////////////////////////////////////////////////////////////

  // Effective level is the larger of threshold and current level
  assign eff_level = (mintthresh_i > mintstatus_i.mil) ? mintthresh_i : mintstatus_i.mil;

  // Request needs a held selection above the effective level and global enable
  assign irq_req_o = valid_q && (level_q > eff_level) && mie_i;

  // Upper id bits are zero
  assign irq_sel_o = '{valid: valid_q, id: 8'(id_q), level: level_q, shv: shv_q};

  // Wake-up looks at the live selection, one cycle ahead of the register
  assign wakeup_o = sel_now_i.valid && (sel_now_i.level > eff_level);

endmodule

/* rtl/clic_csr.sv */
// One saved level of nesting; mtvec low 2 and mtvt low 6 bits read as zero
`timescale 1ns/1ns

module clic_csr import clic_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Software access
  input  logic        csr_valid_i,
  input  csr_cmd_t    csr_i,
  output logic [31:0] csr_rdata_o,

  // Hardware updates from the trap controller
  input  logic        take_i,
  input  logic [7:0]  take_level_i,
  input  logic        mret_i,

  // Register values
  output logic        mie_o,
  output logic [31:0] mtvec_o,
  output logic [31:0] mtvt_o,
  output logic [7:0]  mintthresh_o,
  output mintstatus_t mintstatus_o
);

  logic [31:2] mtvec_q;
  logic [31:6] mtvt_q;
  logic [7:0]  mintthresh_q;
  logic [7:0]  mil_q;
  logic [7:0]  mpil_q;
  logic        mie_q;
  logic        mpie_q;

  logic        sw_we;
  mintstatus_t wdata_ms;

  assign sw_we    = csr_valid_i && csr_i.we;
  assign wdata_ms = mintstatus_t'(csr_i.wdata);

  ////////////////////////////////////////////////////////////////////////////
  // Software-only registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      mtvec_q      <= '0;
      mtvt_q       <= '0;
      mintthresh_q <= 8'd0;
    end else if (sw_we) begin
      case (csr_i.sel)
        CSR_MTVEC:      mtvec_q      <= csr_i.wdata[31:2];
        CSR_MTVT:       mtvt_q       <= csr_i.wdata[31:6];
        CSR_MINTTHRESH: mintthresh_q <= csr_i.wdata[7:0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Status registers, trap entry and return first
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      mie_q  <= 1'b0;
      mpie_q <= 1'b0;
      mil_q  <= 8'd0;
      mpil_q <= 8'd0;
    end else if (take_i) begin
      // Save enable and level, then raise to the trap level
      mpie_q <= mie_q;
      mie_q  <= 1'b0;
      mpil_q <= mil_q;
      mil_q  <= take_level_i;
    end else if (mret_i) begin
      mie_q <= mpie_q;
      mil_q <= mpil_q;
    end else if (sw_we && (csr_i.sel == CSR_MSTATUS)) begin
      mie_q  <= csr_i.wdata[MSTATUS_MIE_BIT];
      mpie_q <= csr_i.wdata[MSTATUS_MPIE_BIT];
    end else if (sw_we && (csr_i.sel == CSR_MINTSTATUS)) begin
      mil_q  <= wdata_ms.mil;
      mpil_q <= wdata_ms.mpil;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    csr_rdata_o = '0;
    case (csr_i.sel)
      CSR_MTVEC:      csr_rdata_o = mtvec_o;
      CSR_MTVT:       csr_rdata_o = mtvt_o;
      CSR_MINTTHRESH: csr_rdata_o = {24'd0, mintthresh_q};
      CSR_MINTSTATUS: csr_rdata_o = mintstatus_o;
      CSR_MSTATUS: begin
        csr_rdata_o[MSTATUS_MIE_BIT]  = mie_q;
        csr_rdata_o[MSTATUS_MPIE_BIT] = mpie_q;
      end
      default: ;
    endcase
  end

  assign mie_o        = mie_q;
  assign mtvec_o      = {mtvec_q, 2'b00};
  assign mtvt_o       = {mtvt_q, 6'd0};
  assign mintthresh_o = mintthresh_q;
  assign mintstatus_o = '{mil: mil_q, rsvd: 16'd0, mpil: mpil_q};

  // Trap entry and return come from one FSM and must never overlap
  a_take_mret: assert property (@(posedge clk) disable iff (!rst_n)
    !(take_i && mret_i))
    else $error("take and mret in the same cycle");

endmodule

/* rtl/clic_trap_ctrl.sv */
// One trap in flight; mret outside WAIT_RET is ignored; vector table entries are 4 bytes
`timescale 1ns/1ns

module clic_trap_ctrl import clic_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // From the interrupt gate
  input  logic        irq_req_i,
  input  clic_sel_t   irq_sel_i,

  // Vector bases from the CSR block
  input  logic [31:0] mtvec_i,
  input  logic [31:0] mtvt_i,

  // Trap port
  output logic        trap_valid_o,
  output trap_t       trap_o,
  input  logic        trap_ready_i,

  // Return from handler
  input  logic        mret_i,

  // CSR update commands
  output logic        take_o,
  output logic [7:0]  take_level_o,
  output logic        mret_o
);

  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    OFFER    = 2'd1,
    WAIT_RET = 2'd2
  } state_e;

  state_e      state_q;
  state_e      state_d;
  trap_t       trap_q;
  logic [31:0] handler_addr;

  ////////////////////////////////////////////////////////////////////////////
  // Handler address
  ////////////////////////////////////////////////////////////////////////////

  // Vectored traps index the table, others share mtvec
  assign handler_addr = irq_sel_i.shv ? (mtvt_i + {22'd0, irq_sel_i.id, 2'b00}) : mtvec_i;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (irq_req_i) begin
          state_d = OFFER;
        end
      end
      OFFER: begin
        // Hold until the core accepts
        if (trap_ready_i) begin
          state_d = WAIT_RET;
        end
      end
      WAIT_RET: begin
        if (mret_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload follows the gate while idle and freezes once offered
  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      trap_q.id    <= irq_sel_i.id;
      trap_q.level <= irq_sel_i.level;
      trap_q.shv   <= irq_sel_i.shv;
      trap_q.addr  <= handler_addr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign trap_valid_o = (state_q == OFFER);
  assign trap_o       = trap_q;

  // CSRs update on the accepting edge
  assign take_o       = trap_valid_o && trap_ready_i;
  assign take_level_o = trap_q.level;

  // Return only counts after a trap was taken
  assign mret_o       = mret_i && (state_q == WAIT_RET);

  // Offered trap holds still until it is taken
  a_trap_stable: assert property (@(posedge clk) disable iff (!rst_n)
    trap_valid_o && !trap_ready_i |=> trap_valid_o && $stable(trap_o))
    else $error("trap changed under back-pressure");

endmodule

/* rtl/clic_irq_top.sv */
// Machine mode CLIC interrupt path; NUM_IRQ from 2 to 256, lines synchronous to clk
`timescale 1ns/1ns

module clic_irq_top import clic_pkg::*; #(
  parameter int NUM_IRQ = 16
) (
  input  logic               clk,
  input  logic               rst_n,

  // Line configuration
  input  logic               cfg_valid_i,
  input  irq_cfg_t           cfg_i,
  output logic               cfg_ready_o,

  // Software CSR access
  input  logic               csr_valid_i,
  input  csr_cmd_t           csr_i,
  output logic [31:0]        csr_rdata_o,

  // Interrupt lines
  input  logic [NUM_IRQ-1:0] irq_i,

  // Trap port and return
  output logic               trap_valid_o,
  output trap_t              trap_o,
  input  logic               trap_ready_i,
  input  logic               mret_i,

  output logic               wakeup_o
);

  // Id bits needed to name every line
  localparam int ID_WIDTH = $clog2(NUM_IRQ);

  clic_sel_t   sel;
  clic_sel_t   sel_now;
  clic_sel_t   irq_sel;
  logic        irq_req;
  logic        mie;
  logic [7:0]  mintthresh;
  mintstatus_t mintstatus;
  logic [31:0] mtvec;
  logic [31:0] mtvt;
  logic        take;
  logic [7:0]  take_level;
  logic        mret_fwd;

  ////////////////////////////////////////////////////////////////////////////
  // Arbitration, gating, trap control and CSRs
  ////////////////////////////////////////////////////////////////////////////

  clic_arbiter #(
    .NUM_IRQ  (NUM_IRQ),
    .ID_WIDTH (ID_WIDTH)
  ) arbiter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_i       (irq_i),
    .cfg_valid_i (cfg_valid_i),
    .cfg_i       (cfg_i),
    .cfg_ready_o (cfg_ready_o),
    .sel_o       (sel),
    .sel_now_o   (sel_now)
  );

  clic_int_gate #(
    .ID_WIDTH (ID_WIDTH)
  ) gate_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .sel_i        (sel),
    .sel_now_i    (sel_now),
    .mie_i        (mie),
    .mintthresh_i (mintthresh),
    .mintstatus_i (mintstatus),
    .irq_req_o    (irq_req),
    .irq_sel_o    (irq_sel),
    .wakeup_o     (wakeup_o)
  );

  clic_trap_ctrl trap_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .irq_req_i    (irq_req),
    .irq_sel_i    (irq_sel),
    .mtvec_i      (mtvec),
    .mtvt_i       (mtvt),
    .trap_valid_o (trap_valid_o),
    .trap_o       (trap_o),
    .trap_ready_i (trap_ready_i),
    .mret_i       (mret_i),
    .take_o       (take),
    .take_level_o (take_level),
    .mret_o       (mret_fwd)
  );

  clic_csr csr_regs_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_valid_i  (csr_valid_i),
    .csr_i        (csr_i),
    .csr_rdata_o  (csr_rdata_o),
    .take_i       (take),
    .take_level_i (take_level),
    .mret_i       (mret_fwd),
    .mie_o        (mie),
    .mtvec_o      (mtvec),
    .mtvt_o       (mtvt),
    .mintthresh_o (mintthresh),
    .mintstatus_o (mintstatus)
  );

endmodule

/* test/tb_clic_irq.sv */
// Drives NUM_IRQ 16 only; irq lines are held low while lines and CSRs are reconfigured
`timescale 1ns/1ns

module tb_clic_irq import clic_pkg::*; ();

  localparam int NUM_IRQ    = 16;
  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 10;
  localparam int NUM_ROUNDS = 24;
  // Reset checks and the tie case count as steps too
  localparam int NUM_STEPS  = NUM_ROUNDS + 2;
  localparam int WAIT_LIMIT = 20;

  logic               clk;
  logic               rst_n;
  logic               cfg_valid_i;
  irq_cfg_t           cfg_i;
  logic               cfg_ready_o;
  logic               csr_valid_i;
  csr_cmd_t           csr_i;
  logic [31:0]        csr_rdata_o;
  logic [NUM_IRQ-1:0] irq_i;
  logic               trap_valid_o;
  trap_t              trap_o;
  logic               trap_ready_i;
  logic               mret_i;
  logic               wakeup_o;

  // Reference model state
  logic               cfg_ie    [NUM_IRQ];
  logic [7:0]         cfg_level [NUM_IRQ];
  logic               cfg_shv   [NUM_IRQ];
  logic [31:0]        m_mtvec;
  logic [31:0]        m_mtvt;
  logic [7:0]         m_thresh;
  logic [7:0]         m_mil;
  logic [7:0]         m_mpil;
  logic               m_mie;
  logic               m_mpie;

  // Expectations seen by the assertions
  logic               trap_allowed;
  trap_t              exp_trap;
  int                 cycle;
  int                 due_cycle;
  logic               wake_check;
  logic               exp_wakeup;
  logic               csr_check;
  logic [31:0]        exp_rdata;
  trap_t              held_trap;
  logic [31:0]        lfsr_q;

  clic_irq_top #(
    .NUM_IRQ (NUM_IRQ)
  ) dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_valid_i  (cfg_valid_i),
    .cfg_i        (cfg_i),
    .cfg_ready_o  (cfg_ready_o),
    .csr_valid_i  (csr_valid_i),
    .csr_i        (csr_i),
    .csr_rdata_o  (csr_rdata_o),
    .irq_i        (irq_i),
    .trap_valid_o (trap_valid_o),
    .trap_o       (trap_o),
    .trap_ready_i (trap_ready_i),
    .mret_i       (mret_i),
    .wakeup_o     (wakeup_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Edge count and last cycle's payload
  always @(posedge clk) begin
    cycle     <= cycle + 1;
    held_trap <= trap_o;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and random bits
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic fail_value(input string name, input logic [63:0] exp_val,
                            input logic [63:0] act_val);
    $display("error at %0t ns: %s expected %0h, got %0h", $time, name, exp_val, act_val);
    abort_run();
  endtask

  task automatic fail_text(input string msg);
    $display("at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Highest nonzero level among enabled pending lines with the lowest id winning a tie
  function automatic clic_sel_t best_line(input logic [NUM_IRQ-1:0] lines);
    clic_sel_t best;
    best = '0;
    for (int i = 0; i < NUM_IRQ; i++) begin
      if (lines[i] && cfg_ie[i] && (cfg_level[i] != 8'd0)) begin
        if (!best.valid || (cfg_level[i] > best.level)) begin
          best = '{valid: 1'b1, id: 8'(i), level: cfg_level[i], shv: cfg_shv[i]};
        end
      end
    end
    return best;
  endfunction

  function automatic logic [7:0] eff_level();
    return (m_thresh > m_mil) ? m_thresh : m_mil;
  endfunction

  function automatic logic [31:0] handler_of(input clic_sel_t s);
    if (s.shv) begin
      return m_mtvt + 32'(s.id) * 4;
    end
    return m_mtvec;
  endfunction

  function automatic logic [31:0] csr_expect(input csr_sel_e sel);
    logic [31:0] v;
    v = '0;
    case (sel)
      CSR_MTVEC:      v = m_mtvec;
      CSR_MTVT:       v = m_mtvt;
      CSR_MINTTHRESH: v = {24'd0, m_thresh};
      CSR_MINTSTATUS: v = {m_mil, 16'd0, m_mpil};
      CSR_MSTATUS: begin
        v[MSTATUS_MIE_BIT]  = m_mie;
        v[MSTATUS_MPIE_BIT] = m_mpie;
      end
      default: ;
    endcase
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Configuration port never stalls outside reset
  a_cfg_ready: assert property (@(posedge clk) disable iff (!rst_n) cfg_ready_o)
    else fail_value("cfg_ready_o", 64'd1, 64'($sampled(cfg_ready_o)));

  a_trap_allowed: assert property (@(posedge clk) trap_valid_o |-> trap_allowed)
    else fail_value("trap_valid_o", 64'd0, 64'd1);

  a_trap_payload: assert property (@(posedge clk) disable iff (!rst_n)
    trap_valid_o |-> (trap_o == exp_trap))
    else fail_value("trap_o", 64'($sampled(exp_trap)), 64'($sampled(trap_o)));

  // Offer appears exactly 4 cycles after the lines rise
  a_trap_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(trap_valid_o) |-> (cycle == due_cycle))
    else fail_value("trap_valid_o rise cycle", 64'($sampled(due_cycle)), 64'($sampled(cycle)));

  a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    trap_valid_o && !trap_ready_i |=> trap_valid_o)
    else fail_value("trap_valid_o", 64'd1, 64'd0);

  a_payload_hold: assert property (@(posedge clk) disable iff (!rst_n)
    trap_valid_o && !trap_ready_i |=> (trap_o == held_trap))
    else fail_value("trap_o", 64'($sampled(held_trap)), 64'($sampled(trap_o)));

  a_wakeup: assert property (@(posedge clk) wake_check |-> (wakeup_o == exp_wakeup))
    else fail_value("wakeup_o", 64'($sampled(exp_wakeup)), 64'($sampled(wakeup_o)));

  a_csr_read: assert property (@(posedge clk) csr_check |-> (csr_rdata_o == exp_rdata))
    else fail_value("csr_rdata_o", 64'($sampled(exp_rdata)), 64'($sampled(csr_rdata_o)));

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks start and end just after a rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic write_cfg(input int idx, input logic ie, input logic [7:0] level,
                           input logic shv);
    cfg_valid_i    = 1'b1;
    cfg_i          = '{idx: 8'(idx), ie: ie, level: level, shv: shv};
    next_cycle();
    cfg_valid_i    = 1'b0;
    cfg_ie[idx]    = ie;
    cfg_level[idx] = level;
    cfg_shv[idx]   = shv;
  endtask

  task automatic write_csr(input csr_sel_e sel, input logic [31:0] data);
    mintstatus_t ms;
    ms          = mintstatus_t'(data);
    csr_valid_i = 1'b1;
    csr_i       = '{sel: sel, we: 1'b1, wdata: data};
    next_cycle();
    csr_valid_i = 1'b0;
    csr_i.we    = 1'b0;
    case (sel)
      CSR_MTVEC:      m_mtvec  = {data[31:2], 2'b00};
      CSR_MTVT:       m_mtvt   = {data[31:6], 6'd0};
      CSR_MINTTHRESH: m_thresh = data[7:0];
      CSR_MINTSTATUS: begin
        m_mil  = ms.mil;
        m_mpil = ms.mpil;
      end
      CSR_MSTATUS: begin
        m_mie  = data[MSTATUS_MIE_BIT];
        m_mpie = data[MSTATUS_MPIE_BIT];
      end
      default: ;
    endcase
  endtask

  task automatic read_csr(input csr_sel_e sel);
    csr_valid_i = 1'b1;
    csr_i       = '{sel: sel, we: 1'b0, wdata: 32'd0};
    exp_rdata   = csr_expect(sel);
    csr_check   = 1'b1;
    next_cycle();
    csr_check   = 1'b0;
    csr_valid_i = 1'b0;
  endtask

  task automatic check_csrs();
    for (int i = 0; i < 5; i++) begin
      read_csr(csr_sel_e'(i));
    end
  endtask

  // Wake-up ignores mie but follows the level rule
  task automatic check_wakeup();
    clic_sel_t best;
    best       = best_line(irq_i);
    exp_wakeup = best.valid && (best.level > eff_level());
    wake_check = 1'b1;
    next_cycle();
    wake_check = 1'b0;
  endtask

  task automatic raise_lines(input logic [NUM_IRQ-1:0] lines);
    clic_sel_t best;
    best         = best_line(lines);
    irq_i        = lines;
    due_cycle    = cycle + 4;
    trap_allowed = best.valid && (best.level > eff_level()) && m_mie;
    exp_trap     = '{id: best.id, level: best.level, shv: best.shv, addr: handler_of(best)};
  endtask

  // Random stall of 0 to 7 cycles before ready
  task automatic accept_trap();
    int waited;
    int stall;
    waited = 0;
    while (!trap_valid_o && (waited < WAIT_LIMIT)) begin
      next_cycle();
      waited++;
    end
    if (!trap_valid_o) begin
      fail_text("no trap was offered for an expected interrupt");
    end else begin
      stall = int'(rand_bits(3));
      repeat (stall) next_cycle();
      trap_ready_i = 1'b1;
      next_cycle();
      trap_ready_i = 1'b0;
      trap_allowed = 1'b0;
      m_mpie       = m_mie;
      m_mie        = 1'b0;
      m_mpil       = m_mil;
      m_mil        = exp_trap.level;
    end
  endtask

  task automatic drop_lines();
    irq_i = '0;
    repeat (4) next_cycle();
  endtask

  task automatic return_from_trap();
    mret_i = 1'b1;
    next_cycle();
    mret_i = 1'b0;
    m_mie  = m_mpie;
    m_mil  = m_mpil;
  endtask

  task automatic run_tie_case();
    write_cfg(2, 1'b1, 8'd200, 1'b1);
    write_cfg(5, 1'b1, 8'd200, 1'b0);
    write_cfg(11, 1'b1, 8'd100, 1'b0);
    write_cfg(7, 1'b0, 8'd250, 1'b0);
    write_csr(CSR_MTVEC, 32'h0000_1003);
    write_csr(CSR_MTVT, 32'h0000_2040);
    write_csr(CSR_MINTTHRESH, 32'd50);
    write_csr(CSR_MSTATUS, 32'h0000_0008);
    // Lines 2, 5, 7 and 11 together
    raise_lines(16'h08a4);
    repeat (2) next_cycle();
    check_wakeup();
    accept_trap();
    drop_lines();
    return_from_trap();
    check_csrs();
  endtask

  task automatic run_round();
    logic [31:0]        word;
    logic [NUM_IRQ-1:0] lines;
    logic               ie;
    logic [7:0]         level;
    logic               shv;
    for (int i = 0; i < NUM_IRQ; i++) begin
      ie    = 1'(rand_bits(1));
      level = 8'(rand_bits(8));
      shv   = 1'(rand_bits(1));
      write_cfg(i, ie, level, shv);
    end
    word = rand_bits(32);
    write_csr(CSR_MTVEC, word);
    word = rand_bits(32);
    write_csr(CSR_MTVT, word);
    word = rand_bits(7);
    write_csr(CSR_MINTTHRESH, word);
    // Low current level so most rounds reach a trap
    word        = '0;
    word[29:24] = 6'(rand_bits(6));
    word[7:0]   = 8'(rand_bits(8));
    write_csr(CSR_MINTSTATUS, word);
    word                   = '0;
    word[MSTATUS_MIE_BIT]  = |rand_bits(2);
    word[MSTATUS_MPIE_BIT] = 1'(rand_bits(1));
    write_csr(CSR_MSTATUS, word);
    lines = NUM_IRQ'(rand_bits(NUM_IRQ));
    raise_lines(lines);
    repeat (2) next_cycle();
    check_wakeup();
    if (trap_allowed) begin
      accept_trap();
      // Winner now sits at mil so wake-up stays low
      check_wakeup();
      read_csr(CSR_MINTSTATUS);
      read_csr(CSR_MSTATUS);
      drop_lines();
      return_from_trap();
      read_csr(CSR_MINTSTATUS);
      read_csr(CSR_MSTATUS);
    end else begin
      repeat (6) next_cycle();
      drop_lines();
    end
    check_wakeup();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    cfg_valid_i  = 1'b0;
    cfg_i        = '0;
    csr_valid_i  = 1'b0;
    csr_i        = '0;
    irq_i        = '0;
    trap_ready_i = 1'b0;
    mret_i       = 1'b0;
    lfsr_q       = 32'd93932;
    cycle        = 0;
    due_cycle    = 0;
    trap_allowed = 1'b0;
    exp_trap     = '0;
    wake_check   = 1'b0;
    exp_wakeup   = 1'b0;
    csr_check    = 1'b0;
    exp_rdata    = '0;
    for (int i = 0; i < NUM_IRQ; i++) begin
      cfg_ie[i]    = 1'b0;
      cfg_level[i] = 8'd0;
      cfg_shv[i]   = 1'b0;
    end
    m_mtvec  = '0;
    m_mtvt   = '0;
    m_thresh = '0;
    m_mil    = '0;
    m_mpil   = '0;
    m_mie    = 1'b0;
    m_mpie   = 1'b0;
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    check_wakeup();
    check_csrs();
    run_tie_case();
    for (int r = 0; r < NUM_ROUNDS; r++) begin
      run_round();
    end
    $display("** PASS **");
    $finish;
  end

  initial begin
    #(NUM_STEPS * 200 * CLK_PERIOD);
    fail_text("watchdog expired before the test sequence finished");
  end

endmodule

/* sources.f */
rtl/clic_pkg.sv
rtl/clic_arbiter.sv
rtl/clic_int_gate.sv
rtl/clic_csr.sv
rtl/clic_trap_ctrl.sv
rtl/clic_irq_top.sv
test/tb_clic_irq.sv
